/* hdl/cluster_bootrom.sv */
// Read-only table; done_o comes two cycles after rom_req_i and a write only reports error
`timescale 1ns/1ns
`default_nettype none

module cluster_bootrom
  import cluster_ctrl_pkg::*;
(
  input  logic              soc_clk_i,
  input  logic              rst_i,
  input  logic              rom_req_i,
  input  logic              write_i,
  input  bus_addr_u         addr_i,
  output logic              done_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              error_o
);

  logic [DATA_W-1:0] rom_table [ROM_DEPTH];
  logic [DATA_W-1:0] rom_word;
  logic [DATA_W-1:0] data_q;
  logic              req_q;
  logic              we_q;

  // Tag in the upper half, word index in the lower half
  for (genvar i = 0; i < ROM_DEPTH; i++) begin : gen_rom_table
    assign rom_table[i] = {ROM_TAG, (DATA_W/2)'(i)};
  end

  assign rom_word = rom_table[addr_i.rom.rom_idx];

  // ------------------------------
  // First stage, the ROM read
  // ------------------------------
  always_ff @(posedge soc_clk_i) begin
    if (rst_i) begin
      req_q <= 1'b0;
      we_q  <= 1'b0;
    end else begin
      req_q <= rom_req_i;
      we_q  <= rom_req_i & write_i;
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (rom_req_i) begin
      data_q <= write_i ? '0 : rom_word;
    end
  end

  // ------------------------------
  // Second stage, delayed reply
  // ------------------------------
  always_ff @(posedge soc_clk_i) begin
    if (rst_i) begin
      done_o  <= 1'b0;
      error_o <= 1'b0;
    end else begin
      done_o  <= req_q;
      error_o <= we_q;
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (req_q) begin
      rdata_o <= data_q;
    end
  end

endmodule

`default_nettype wire

/* hdl/cluster_bus_router.sv */
// One transaction in flight; a target must return exactly one done strobe per request strobe
`timescale 1ns/1ns
`default_nettype none

module cluster_bus_router
  import cluster_ctrl_pkg::*;
(
  input  logic              soc_clk_i,
  input  logic              rst_i,
  // Host request
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic              req_write_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic [DATA_W-1:0] req_wdata_i,
  // Host response
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output logic [DATA_W-1:0] rsp_rdata_o,
  output logic              rsp_error_o,
  // Shared target request fields
  output logic              cfg_req_o,
  output logic              rom_req_o,
  output logic              tgt_write_o,
  output bus_addr_u         tgt_addr_o,
  output logic [DATA_W-1:0] tgt_wdata_o,
  // Target replies
  input  logic              cfg_done_i,
  input  logic [DATA_W-1:0] cfg_rdata_i,
  input  logic              cfg_error_i,
  input  logic              rom_done_i,
  input  logic [DATA_W-1:0] rom_rdata_i,
  input  logic              rom_error_i
);

  bus_addr_u req_addr;
  logic      busy_q;
  logic      accept;
  logic      tgt_done;

  assign req_addr = req_addr_i;

  // Ready only with nothing pending and no held response
  assign req_ready_o = ~busy_q & ~rsp_valid_o;
  assign accept      = req_valid_i & req_ready_o;
  assign tgt_done    = cfg_done_i | rom_done_i;

  // ------------------------------
  // Handshake state
  // ------------------------------
  always_ff @(posedge soc_clk_i) begin
    if (rst_i) begin
      busy_q      <= 1'b0;
      rsp_valid_o <= 1'b0;
      cfg_req_o   <= 1'b0;
      rom_req_o   <= 1'b0;
    end else begin
      // One-cycle strobe to the target picked by the region bit
      cfg_req_o <= accept & ~req_addr.cfg.region;
      rom_req_o <= accept & req_addr.cfg.region;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (tgt_done) begin
        busy_q <= 1'b0;
      end
      if (tgt_done) begin
        rsp_valid_o <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_o <= 1'b0;
      end
    end
  end

  // Request fields toward the targets
  always_ff @(posedge soc_clk_i) begin
    if (accept) begin
      tgt_write_o <= req_write_i;
      tgt_addr_o  <= req_addr;
      tgt_wdata_o <= req_wdata_i;
    end
  end

  // Held response, stable until the host takes it
  always_ff @(posedge soc_clk_i) begin
    if (tgt_done) begin
      rsp_rdata_o <= cfg_done_i ? cfg_rdata_i : rom_rdata_i;
      rsp_error_o <= cfg_done_i ? cfg_error_i : rom_error_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/cluster_cfg_regs.sv */
// Reply one cycle after cfg_req_i; only word-aligned offsets 0x000 to 0x00C are mapped
`timescale 1ns/1ns
`default_nettype none

module cluster_cfg_regs
  import cluster_ctrl_pkg::*;
(
  input  logic                    soc_clk_i,
  input  logic                    rst_i,
  // Target side of the router
  input  logic                    cfg_req_i,
  input  logic                    write_i,
  input  bus_addr_u               addr_i,
  input  logic [DATA_W-1:0]       wdata_i,
  output logic                    done_o,
  output logic [DATA_W-1:0]       rdata_o,
  output logic                    error_o,
  // Power manager reset requests
  input  logic [NUM_CLUSTERS-1:0] pmu_rst_clusters_i,
  // Per-cluster controls
  output logic [NUM_CLUSTERS-1:0] cluster_rst_o,
  output logic [NUM_CLUSTERS-1:0] cluster_clk_en_o,
  output logic [NUM_CLUSTERS-1:0] wide_mem_bypass_o,
  output logic [DATA_W-1:0]       boot_addr_o
);

  logic [NUM_CLUSTERS-1:0] soft_rst_q;
  logic [NUM_CLUSTERS-1:0] clk_gate_q;
  logic [NUM_CLUSTERS-1:0] bypass_q;
  logic [DATA_W-1:0]       boot_addr_q;
  logic                    mapped;
  logic [DATA_W-1:0]       rdata_d;

  // Only the four word offsets below 0x010 decode
  assign mapped = (addr_i.cfg.unused == '0) && (addr_i.cfg.byte_sel == 2'b00);

  always_comb begin
    rdata_d = '0;
    if (mapped) begin
      case (addr_i.cfg.reg_idx)
        REG_RESET_OFS[3:2]:     rdata_d = {{(DATA_W-NUM_CLUSTERS){1'b0}}, soft_rst_q};
        REG_CLKGATE_OFS[3:2]:   rdata_d = {{(DATA_W-NUM_CLUSTERS){1'b0}}, clk_gate_q};
        REG_BYPASS_OFS[3:2]:    rdata_d = {{(DATA_W-NUM_CLUSTERS){1'b0}}, bypass_q};
        REG_BOOT_ADDR_OFS[3:2]: rdata_d = boot_addr_q;
        default:                rdata_d = '0;
      endcase
    end
  end

  // ------------------------------
  // Register state
  // ------------------------------
  always_ff @(posedge soc_clk_i) begin
    if (rst_i) begin
      soft_rst_q  <= '0;
      clk_gate_q  <= '0;
      bypass_q    <= '0;
      boot_addr_q <= BOOT_ADDR_RESET;
    end else if (cfg_req_i && write_i && mapped) begin
      case (addr_i.cfg.reg_idx)
        REG_RESET_OFS[3:2]:     soft_rst_q  <= wdata_i[NUM_CLUSTERS-1:0];
        REG_CLKGATE_OFS[3:2]:   clk_gate_q  <= wdata_i[NUM_CLUSTERS-1:0];
        REG_BYPASS_OFS[3:2]:    bypass_q    <= wdata_i[NUM_CLUSTERS-1:0];
        REG_BOOT_ADDR_OFS[3:2]: boot_addr_q <= wdata_i;
        default:                boot_addr_q <= boot_addr_q;
      endcase
    end
  end

  // Reply stage
  always_ff @(posedge soc_clk_i) begin
    if (rst_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= cfg_req_i;
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (cfg_req_i) begin
      rdata_o <= write_i ? '0 : rdata_d;
      error_o <= ~mapped;
    end
  end

  // ------------------------------
  // Cluster controls
  // ------------------------------
  // Global, software and power manager resets all hold the cluster
  assign cluster_rst_o     = soft_rst_q | pmu_rst_clusters_i | {NUM_CLUSTERS{rst_i}};
  // Gate bit set means clock stopped
  assign cluster_clk_en_o  = ~clk_gate_q;
  assign wide_mem_bypass_o = bypass_q;
  assign boot_addr_o       = boot_addr_q;

endmodule

`default_nettype wire

/* hdl/cluster_ctrl_pkg.sv */
// One clock domain only; address field widths assume ROM_DEPTH is a power of two below 2**10
`default_nettype none

package cluster_ctrl_pkg;

  // ------------------------------
  // Bus and cluster sizes
  // ------------------------------
  localparam int unsigned NUM_CLUSTERS = 4;
  localparam int unsigned ADDR_W       = 16;
  localparam int unsigned DATA_W       = 32;

  // ------------------------------
  // Address map
  // ------------------------------
  // Bit 12 low selects the config registers, high selects the boot ROM
  localparam int unsigned REGION_BIT = 12;

  localparam logic [REGION_BIT-1:0] REG_RESET_OFS     = 12'h000;
  localparam logic [REGION_BIT-1:0] REG_CLKGATE_OFS   = 12'h004;
  localparam logic [REGION_BIT-1:0] REG_BYPASS_OFS    = 12'h008;
  localparam logic [REGION_BIT-1:0] REG_BOOT_ADDR_OFS = 12'h00C;

  // ------------------------------
  // Reset values and ROM
  // ------------------------------
  localparam logic [DATA_W-1:0]   BOOT_ADDR_RESET = 32'h8000_0000;
  localparam int unsigned         ROM_DEPTH       = 64;
  localparam logic [DATA_W/2-1:0] ROM_TAG         = 16'hB007;

  // Field widths of the two address views
  localparam int unsigned UPPER_W   = ADDR_W - REGION_BIT - 1;
  localparam int unsigned ROM_IDX_W = $clog2(ROM_DEPTH);

  // Same bus address word, seen by the register block or by the ROM
  typedef union packed {
    struct packed {
      logic [UPPER_W-1:0]    upper;
      logic                  region;
      logic [REGION_BIT-5:0] unused;
      logic [1:0]            reg_idx;
      logic [1:0]            byte_sel;
    } cfg;
    struct packed {
      logic [UPPER_W-1:0]                upper;
      logic                              region;
      logic [REGION_BIT-ROM_IDX_W-3:0]   unused;
      logic [ROM_IDX_W-1:0]              rom_idx;
      logic [1:0]                        byte_sel;
    } rom;
  } bus_addr_u;

endpackage

`default_nettype wire

/* hdl/cluster_ctrl_top.sv */
// Single clock soc_clk_i; cluster clock enables stand in for real clock-gating cells
`timescale 1ns/1ns
`default_nettype none

module cluster_ctrl_top
  import cluster_ctrl_pkg::*;
(
  input  logic                    soc_clk_i,
  input  logic                    rst_i,
  // Host request
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  logic                    req_write_i,
  input  logic [ADDR_W-1:0]       req_addr_i,
  input  logic [DATA_W-1:0]       req_wdata_i,
  // Host response
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i,
  output logic [DATA_W-1:0]       rsp_rdata_o,
  output logic                    rsp_error_o,
  // Cluster control
  input  logic [NUM_CLUSTERS-1:0] pmu_rst_clusters_i,
  output logic [NUM_CLUSTERS-1:0] cluster_rst_o,
  output logic [NUM_CLUSTERS-1:0] cluster_clk_en_o,
  output logic [NUM_CLUSTERS-1:0] wide_mem_bypass_o,
  output logic [DATA_W-1:0]       boot_addr_o
);

  logic              cfg_req;
  logic              rom_req;
  logic              tgt_write;
  bus_addr_u         tgt_addr;
  logic [DATA_W-1:0] tgt_wdata;
  logic              cfg_done;
  logic [DATA_W-1:0] cfg_rdata;
  logic              cfg_error;
  logic              rom_done;
  logic [DATA_W-1:0] rom_rdata;
  logic              rom_error;

  // ------------------------------
  // Host bus decode
  // ------------------------------
  cluster_bus_router u_router (
    .soc_clk_i   (soc_clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_write_i (req_write_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_error_o (rsp_error_o),
    .cfg_req_o   (cfg_req),
    .rom_req_o   (rom_req),
    .tgt_write_o (tgt_write),
    .tgt_addr_o  (tgt_addr),
    .tgt_wdata_o (tgt_wdata),
    .cfg_done_i  (cfg_done),
    .cfg_rdata_i (cfg_rdata),
    .cfg_error_i (cfg_error),
    .rom_done_i  (rom_done),
    .rom_rdata_i (rom_rdata),
    .rom_error_i (rom_error)
  );

  // Config registers and cluster controls
  cluster_cfg_regs u_cfg_regs (
    .soc_clk_i          (soc_clk_i),
    .rst_i              (rst_i),
    .cfg_req_i          (cfg_req),
    .write_i            (tgt_write),
    .addr_i             (tgt_addr),
    .wdata_i            (tgt_wdata),
    .done_o             (cfg_done),
    .rdata_o            (cfg_rdata),
    .error_o            (cfg_error),
    .pmu_rst_clusters_i (pmu_rst_clusters_i),
    .cluster_rst_o      (cluster_rst_o),
    .cluster_clk_en_o   (cluster_clk_en_o),
    .wide_mem_bypass_o  (wide_mem_bypass_o),
    .boot_addr_o        (boot_addr_o)
  );

  // Boot ROM
  cluster_bootrom u_bootrom (
    .soc_clk_i (soc_clk_i),
    .rst_i     (rst_i),
    .rom_req_i (rom_req),
    .write_i   (tgt_write),
    .addr_i    (tgt_addr),
    .done_o    (rom_done),
    .rdata_o   (rom_rdata),
    .error_o   (rom_error)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module cluster_ctrl_tb \
  -o sim_cluster_ctrl > build.log 2>&1 \
  && ./obj_dir/sim_cluster_ctrl > sim.log 2>&1 \
  && grep -q "^No errors$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

exit 0

/* src.f */
hdl/cluster_ctrl_pkg.sv
hdl/cluster_cfg_regs.sv
hdl/cluster_bootrom.sv
hdl/cluster_bus_router.sv
hdl/cluster_ctrl_top.sv
verification/cluster_ctrl_tb.sv

/* verification/cluster_ctrl_tb.sv */
// Drives one bus transaction at a time; build with Verilator --timing and --assert
`timescale 1ns/1ns
`default_nettype none

module cluster_ctrl_tb
  import cluster_ctrl_pkg::*;
();

  localparam int                TIMEOUT_CYCLES = 2000;
  // Region bit set selects the boot ROM
  localparam logic [ADDR_W-1:0] ROM_BASE       = 16'h1000;
  localparam logic [DATA_W-1:0] CLUSTER_MASK   = {{(DATA_W-NUM_CLUSTERS){1'b0}},
                                                  {NUM_CLUSTERS{1'b1}}};

  logic                    soc_clk_i = 1'b0;
  logic                    rst_i;
  logic                    req_valid_i;
  logic                    req_ready_o;
  logic                    req_write_i;
  logic [ADDR_W-1:0]       req_addr_i;
  logic [DATA_W-1:0]       req_wdata_i;
  logic                    rsp_valid_o;
  logic                    rsp_ready_i;
  logic [DATA_W-1:0]       rsp_rdata_o;
  logic                    rsp_error_o;
  logic [NUM_CLUSTERS-1:0] pmu_rst_clusters_i;
  logic [NUM_CLUSTERS-1:0] cluster_rst_o;
  logic [NUM_CLUSTERS-1:0] cluster_clk_en_o;
  logic [NUM_CLUSTERS-1:0] wide_mem_bypass_o;
  logic [DATA_W-1:0]       boot_addr_o;

  integer            seed;
  int                cycles = 0;
  int                errors = 0;
  int                checks = 0;
  int                tests = 0;
  int                test_err_start = 0;
  int                outstanding = 0;
  string             test_name = "reset_state";
  // Expected register contents, indexed by word offset
  logic [DATA_W-1:0] exp_regs [4];

  cluster_ctrl_top u_dut (.*);

  always #4 soc_clk_i = ~soc_clk_i;

  always @(posedge soc_clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  function automatic void note_failure(input string msg);
    errors++;
    $display("%0t %s: %s", $time, test_name, msg);
  endfunction

  task automatic check_value(input string what, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
    checks++;
    assert (act === exp)
      else begin
        errors++;
        $display("ERROR %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
      end
  endtask

  // ------------------------------
  // Protocol checks
  // ------------------------------
  assert property (@(posedge soc_clk_i) disable iff (rst_i)
    (rsp_valid_o && !rsp_ready_i) |=>
      (rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_error_o)))
    else note_failure("held response dropped or changed before the host took it");

  assert property (@(posedge soc_clk_i) disable iff (rst_i) rsp_valid_o |-> !req_ready_o)
    else note_failure("request ready while a response is waiting");

  assert property (@(posedge soc_clk_i) disable iff (rst_i)
    (req_valid_i && req_ready_o) |=> !req_ready_o)
    else note_failure("second request could be taken while one is in flight");

  // One response per accepted request, in order
  always @(posedge soc_clk_i) begin
    if (rst_i) begin
      outstanding <= 0;
    end else begin
      if (outstanding != 0) begin
        assert (!req_ready_o)
          else note_failure("request ready with another still outstanding");
      end
      if (rsp_valid_o && rsp_ready_i) begin
        assert (outstanding == 1)
          else note_failure("response delivered without a matching request");
      end
      outstanding <= outstanding + ((req_valid_i && req_ready_o) ? 1 : 0)
                     - ((rsp_valid_o && rsp_ready_i) ? 1 : 0);
    end
  end

  // ------------------------------
  // Bus driver
  // ------------------------------
  // Called 1 ns after an edge; hold is the number of cycles the response is back-pressured
  task automatic bus_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] wdata, input int hold,
                          output logic [DATA_W-1:0] rdata, output logic err);
    req_valid_i = 1'b1;
    req_write_i = wr;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    // Ready seen here stays put through the next edge
    while (!req_ready_o) begin
      @(posedge soc_clk_i);
      #1;
    end
    rsp_ready_i = (hold == 0);
    @(posedge soc_clk_i);
    #1;
    req_valid_i = 1'b0;
    while (!rsp_valid_o) begin
      @(posedge soc_clk_i);
      #1;
    end
    repeat (hold) begin
      @(posedge soc_clk_i);
      #1;
    end
    rdata       = rsp_rdata_o;
    err         = rsp_error_o;
    rsp_ready_i = 1'b1;
    @(posedge soc_clk_i);
    #1;
  endtask

  task automatic reg_write(input int idx, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] rd;
    logic              er;
    bus_xfer(1'b1, ADDR_W'(idx * 4), data, 0, rd, er);
    check_value("write error flag", '0, DATA_W'(er));
    exp_regs[idx] = (idx == 3) ? data : (data & CLUSTER_MASK);
  endtask

  task automatic reg_read(input int idx, input int hold);
    logic [DATA_W-1:0] rd;
    logic              er;
    bus_xfer(1'b0, ADDR_W'(idx * 4), '0, hold, rd, er);
    check_value($sformatf("read reg %0d", idx), exp_regs[idx], rd);
    check_value("read error flag", '0, DATA_W'(er));
  endtask

  // Tag in the upper half, word index in the lower half
  function automatic logic [DATA_W-1:0] rom_word_of(input logic [5:0] idx);
    return {ROM_TAG, {(DATA_W/2-6){1'b0}}, idx};
  endfunction

  task automatic rom_read(input logic [5:0] idx, input int hold);
    logic [DATA_W-1:0] rd;
    logic              er;
    bus_xfer(1'b0, ROM_BASE | ADDR_W'({idx, 2'b00}), '0, hold, rd, er);
    check_value($sformatf("rom word %0d", idx), rom_word_of(idx), rd);
    check_value("rom error flag", '0, DATA_W'(er));
  endtask

  task automatic finish_test(input string next_name);
    tests++;
    $display("test %s done, %0d errors", test_name, errors - test_err_start);
    test_err_start = errors;
    test_name      = next_name;
  endtask

  task automatic check_outputs();
    check_value("bypass out", exp_regs[2], DATA_W'(wide_mem_bypass_o));
    check_value("boot addr out", exp_regs[3], boot_addr_o);
    check_value("clk enable out", ~exp_regs[1] & CLUSTER_MASK, DATA_W'(cluster_clk_en_o));
  endtask

  initial begin
    logic [DATA_W-1:0]       rd;
    logic                    er;
    logic [DATA_W-1:0]       rnd;
    logic [NUM_CLUSTERS-1:0] pmu;
    logic [5:0]              idx;
    seed               = 34049;
    rst_i              = 1'b1;
    req_valid_i        = 1'b0;
    req_write_i        = 1'b0;
    req_addr_i         = '0;
    req_wdata_i        = '0;
    rsp_ready_i        = 1'b1;
    pmu_rst_clusters_i = '0;
    exp_regs[0] = '0;
    exp_regs[1] = '0;
    exp_regs[2] = '0;
    exp_regs[3] = BOOT_ADDR_RESET;

    // ------------------------------
    // Reset state
    // ------------------------------
    repeat (3) @(posedge soc_clk_i);
    #1;
    check_value("cluster reset in reset", CLUSTER_MASK, DATA_W'(cluster_rst_o));
    repeat (2) @(posedge soc_clk_i);
    #1;
    rst_i = 1'b0;
    @(posedge soc_clk_i);
    #1;
    check_value("cluster reset after reset", '0, DATA_W'(cluster_rst_o));
    check_value("req ready after reset", 32'd1, DATA_W'(req_ready_o));
    check_outputs();
    for (int i = 0; i < 4; i++) reg_read(i, 0);
    finish_test("reg_round_trip");

    for (int r = 0; r < 4; r++) begin
      for (int i = 0; i < 4; i++) reg_write(i, $random(seed));
      for (int i = 0; i < 4; i++) reg_read(i, 0);
      check_outputs();
    end
    finish_test("combined_reset");

    for (int r = 0; r < 8; r++) begin
      reg_write(0, $random(seed));
      rnd = $random(seed);
      pmu = rnd[NUM_CLUSTERS-1:0];
      pmu_rst_clusters_i = pmu;
      @(posedge soc_clk_i);
      #1;
      check_value("cluster reset", exp_regs[0] | DATA_W'(pmu), DATA_W'(cluster_rst_o));
    end
    pmu_rst_clusters_i = '0;
    reg_write(0, '0);
    finish_test("boot_rom");

    for (int r = 0; r < 16; r++) begin
      rnd = $random(seed);
      rom_read(rnd[5:0], 0);
    end
    rnd = $random(seed);
    idx = rnd[5:0];
    bus_xfer(1'b1, ROM_BASE | ADDR_W'({idx, 2'b00}), $random(seed), 0, rd, er);
    check_value("rom write error flag", 32'd1, DATA_W'(er));
    rom_read(idx, 0);
    finish_test("unmapped_reg");

    bus_xfer(1'b0, 16'h0010, '0, 0, rd, er);
    check_value("unmapped read error flag", 32'd1, DATA_W'(er));
    check_value("unmapped read data", '0, rd);
    bus_xfer(1'b1, 16'h0010, $random(seed), 0, rd, er);
    check_value("unmapped write error flag", 32'd1, DATA_W'(er));
    // A rejected write must not land in any register
    for (int i = 0; i < 4; i++) reg_read(i, 0);
    finish_test("handshake");

    for (int r = 0; r < 10; r++) begin
      rnd = $random(seed);
      if (r % 2 == 0) begin
        reg_read(int'(rnd[1:0]), 1 + int'(rnd[10:8]));
      end else begin
        rom_read(rnd[7:2], 1 + int'(rnd[10:8]));
      end
    end
    check_value("outstanding at end", '0, DATA_W'(outstanding));
    finish_test("");

    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
